// ==== verilog/u1e_pkg.sv ====
// u1e radio i/o shared definitions
// widths, host register map, spi timing and the structs passed between blocks
`default_nettype none

package u1e_pkg;

   ///////////////////////////////////////////////////////////////////////
   // widths
   localparam int DAC_W  = 14;            // dac sample
   localparam int ADC_W  = 12;            // adc sample
   localparam int REG_W  = 16;            // host data
   localparam int ADDR_W = 4;             // host address

   // spi engine
   localparam int SPI_MAX_BITS = 24;      // longest transfer
   localparam int SPI_CNT_W    = $clog2(SPI_MAX_BITS + 1);
   localparam int SCLK_DIV     = 4;       // clk_fpga cycles per sclk half period
   localparam int SCLK_CNT_W   = $clog2(SCLK_DIV);
   localparam int NUM_SLAVES   = 3;       // 0 rx board, 1 tx board, 2 codec
   localparam int SLV_W        = 2;

   ///////////////////////////////////////////////////////////////////////
   // host register map
   localparam logic [ADDR_W-1:0] REG_SPI_LO    = 4'd0;
   localparam logic [ADDR_W-1:0] REG_SPI_HI    = 4'd1;
   localparam logic [ADDR_W-1:0] REG_SPI_CTRL  = 4'd2;   // write starts a transfer
   localparam logic [ADDR_W-1:0] REG_SPI_RX_LO = 4'd3;
   localparam logic [ADDR_W-1:0] REG_SPI_RX_HI = 4'd4;
   localparam logic [ADDR_W-1:0] REG_TX_I      = 4'd5;
   localparam logic [ADDR_W-1:0] REG_TX_Q      = 4'd6;
   localparam logic [ADDR_W-1:0] REG_RX_I      = 4'd7;
   localparam logic [ADDR_W-1:0] REG_RX_Q      = 4'd8;
   localparam logic [ADDR_W-1:0] REG_CGEN      = 4'd9;   // sync_b, ref_sel, status
   localparam logic [ADDR_W-1:0] REG_OVR       = 4'd10;  // sticky overrange, write clears

   ///////////////////////////////////////////////////////////////////////
   // structs
   typedef struct packed {
      logic [SLV_W-1:0]        slave;     // target slave index
      logic [SPI_CNT_W-1:0]    nbits;     // bits to shift, 1..24
      logic [SPI_MAX_BITS-1:0] data;      // right aligned
   } spi_cmd_t;

   typedef struct packed {
      logic [DAC_W-1:0] i;
      logic [DAC_W-1:0] q;
   } tx_pair_t;

   typedef struct packed {
      logic [REG_W-1:0] i;                // sign extended
      logic [REG_W-1:0] q;
   } rx_pair_t;

endpackage

`default_nettype wire

// ==== verilog/spi_master.sv ====
// spi master for the three radio peripherals
// mode 0, msb first, clock divided from clk_fpga
// gates sclk/mosi onto the selected slave only, ors the enabled miso lines
`timescale 1ns/10ps
`default_nettype none

module spi_master
  (
   input  logic                                   clk_fpga,
   input  logic                                   arst_n,
   input  logic                                   spi_start,   // one cycle, with spi_cmd
   input  u1e_pkg::spi_cmd_t                      spi_cmd,
   output logic                                   spi_busy,
   output logic [u1e_pkg::SPI_MAX_BITS-1:0]       spi_rx_data, // right aligned
   output logic [u1e_pkg::NUM_SLAVES-1:0]         sclk,
   output logic [u1e_pkg::NUM_SLAVES-1:0]         mosi,
   output logic [u1e_pkg::NUM_SLAVES-1:0]         sen_n,
   input  logic [u1e_pkg::NUM_SLAVES-1:0]         miso
   );

   localparam logic [u1e_pkg::SCLK_CNT_W-1:0] DIV_LAST =
      u1e_pkg::SCLK_CNT_W'(u1e_pkg::SCLK_DIV - 1);

   logic                               busy_r;
   logic                               sclk_r;     // undivided spi clock, before gating
   logic [u1e_pkg::SCLK_CNT_W-1:0]     div_cnt;
   logic [u1e_pkg::SPI_CNT_W-1:0]      bit_cnt;    // bits still to go
   logic [u1e_pkg::SLV_W-1:0]          sel;
   logic [u1e_pkg::SPI_MAX_BITS-1:0]   tx_sr;      // msb drives mosi
   logic [u1e_pkg::SPI_MAX_BITS-1:0]   rx_sr;
   logic [u1e_pkg::NUM_SLAVES-1:0]     sel_onehot;
   logic                               miso_in;

   ///////////////////////////////////////////////////////////////////////
   // shift engine
   always_ff @(posedge clk_fpga or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy_r  <= 1'b0;
         sclk_r  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
         sel     <= '0;
         tx_sr   <= '0;
         rx_sr   <= '0;
      end
      else if (spi_start)
      begin
         // command already checked upstream
         busy_r  <= 1'b1;
         sclk_r  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= spi_cmd.nbits;
         sel     <= spi_cmd.slave;
         tx_sr   <= spi_cmd.data << (u1e_pkg::SPI_MAX_BITS - spi_cmd.nbits); // bit n-1 to top
         rx_sr   <= '0;
      end
      else if (busy_r)
      begin
         if (bit_cnt == '0)
            busy_r <= 1'b0;                       // one cycle after last falling edge
         else if (div_cnt == DIV_LAST)
         begin
            div_cnt <= '0;
            sclk_r  <= ~sclk_r;
            if (!sclk_r)                          // rising, sample miso
               rx_sr <= {rx_sr[u1e_pkg::SPI_MAX_BITS-2:0], miso_in};
            else
            begin                                 // falling, next bit out
               tx_sr   <= tx_sr << 1;
               bit_cnt <= bit_cnt - 1'b1;
            end
         end
         else
            div_cnt <= div_cnt + 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // per slave gating
   assign sel_onehot = u1e_pkg::NUM_SLAVES'(1) << sel;
   assign sen_n      = ~({u1e_pkg::NUM_SLAVES{busy_r}} & sel_onehot);   // all high when idle

   // unselected slaves see clock and data low
   assign sclk    = ~sen_n & {u1e_pkg::NUM_SLAVES{sclk_r}};
   assign mosi    = ~sen_n & {u1e_pkg::NUM_SLAVES{tx_sr[u1e_pkg::SPI_MAX_BITS-1]}};
   assign miso_in = |(~sen_n & miso);            // shared read-back line

   assign spi_busy    = busy_r;
   assign spi_rx_data = rx_sr;

endmodule

`default_nettype wire

// ==== verilog/radio_regs.sv ====
// host register bank for the radio i/o block
// decodes writes, checks and launches spi commands, holds tx samples
// and clock-generator controls, registers read data every cycle
`timescale 1ns/10ps
`default_nettype none

module radio_regs
  (
   input  logic                                clk_fpga,
   input  logic                                arst_n,
   input  logic [u1e_pkg::ADDR_W-1:0]          host_addr,
   input  logic [u1e_pkg::REG_W-1:0]           host_wdata,
   input  logic                                host_we,
   output logic [u1e_pkg::REG_W-1:0]           host_rdata,
   output logic                                spi_start,
   output u1e_pkg::spi_cmd_t                   spi_cmd,
   input  logic                                spi_busy,
   input  logic [u1e_pkg::SPI_MAX_BITS-1:0]    spi_rx_data,
   output u1e_pkg::tx_pair_t                   tx_pair,
   input  u1e_pkg::rx_pair_t                   rx_pair,
   input  logic [1:0]                          ovr,
   output logic                                ovr_clear,
   output logic                                cgen_sync_b,
   output logic                                cgen_ref_sel,
   input  logic [2:0]                          cgen_status  // status, lock, refmon
   );

   localparam int HI_W = u1e_pkg::SPI_MAX_BITS - u1e_pkg::REG_W;

   logic [u1e_pkg::REG_W-1:0]       spi_lo;
   logic [HI_W-1:0]                 spi_hi;
   logic [u1e_pkg::SLV_W-1:0]       ctrl_slave;
   logic [u1e_pkg::SPI_CNT_W-1:0]   ctrl_nbits;
   logic                            ctrl_wr;
   logic                            cmd_ok;

   ///////////////////////////////////////////////////////////////////////
   // write decode
   assign ctrl_slave = host_wdata[1:0];
   assign ctrl_nbits = host_wdata[8:4];
   assign ctrl_wr    = host_we && (host_addr == u1e_pkg::REG_SPI_CTRL);

   // bad index, bad length or engine in use -> write dropped
   assign cmd_ok = (ctrl_slave < u1e_pkg::NUM_SLAVES) && (ctrl_nbits != '0)
                   && (ctrl_nbits <= u1e_pkg::SPI_MAX_BITS) && !spi_busy && !spi_start;

   assign ovr_clear = host_we && (host_addr == u1e_pkg::REG_OVR);   // any data clears

   always_ff @(posedge clk_fpga)
   begin
      if (host_we && host_addr == u1e_pkg::REG_SPI_LO) spi_lo <= host_wdata;
      if (host_we && host_addr == u1e_pkg::REG_SPI_HI) spi_hi <= host_wdata[HI_W-1:0];
      if (ctrl_wr && cmd_ok)
         spi_cmd <= '{slave: ctrl_slave, nbits: ctrl_nbits, data: {spi_hi, spi_lo}};
   end

   ///////////////////////////////////////////////////////////////////////
   // control and read-back
   always_ff @(posedge clk_fpga or negedge arst_n)
   begin
      if (!arst_n)
      begin
         spi_start    <= 1'b0;
         tx_pair      <= '0;         // dac bus idles at 0
         cgen_sync_b  <= 1'b1;       // clock gen not held in sync
         cgen_ref_sel <= 1'b0;
         host_rdata   <= '0;
      end
      else
      begin
         spi_start <= ctrl_wr && cmd_ok;                   // single cycle pulse
         if (host_we && host_addr == u1e_pkg::REG_TX_I)
            tx_pair.i <= host_wdata[u1e_pkg::DAC_W-1:0];
         if (host_we && host_addr == u1e_pkg::REG_TX_Q)
            tx_pair.q <= host_wdata[u1e_pkg::DAC_W-1:0];
         if (host_we && host_addr == u1e_pkg::REG_CGEN)
         begin
            cgen_sync_b  <= host_wdata[0];
            cgen_ref_sel <= host_wdata[1];
         end
         case (host_addr)
            u1e_pkg::REG_SPI_LO:    host_rdata <= spi_lo;
            u1e_pkg::REG_SPI_HI:    host_rdata <= {{(u1e_pkg::REG_W-HI_W){1'b0}}, spi_hi};
            u1e_pkg::REG_SPI_CTRL:  host_rdata <= {{(u1e_pkg::REG_W-1){1'b0}}, spi_busy};
            u1e_pkg::REG_SPI_RX_LO: host_rdata <= spi_rx_data[u1e_pkg::REG_W-1:0];
            u1e_pkg::REG_SPI_RX_HI: host_rdata <= {{(u1e_pkg::REG_W-HI_W){1'b0}},
                                                   spi_rx_data[u1e_pkg::SPI_MAX_BITS-1:u1e_pkg::REG_W]};
            u1e_pkg::REG_TX_I:      host_rdata <= {{(u1e_pkg::REG_W-u1e_pkg::DAC_W){1'b0}}, tx_pair.i};
            u1e_pkg::REG_TX_Q:      host_rdata <= {{(u1e_pkg::REG_W-u1e_pkg::DAC_W){1'b0}}, tx_pair.q};
            u1e_pkg::REG_RX_I:      host_rdata <= rx_pair.i;
            u1e_pkg::REG_RX_Q:      host_rdata <= rx_pair.q;
            u1e_pkg::REG_CGEN:      host_rdata <= {11'b0, cgen_status, cgen_ref_sel, cgen_sync_b};
            u1e_pkg::REG_OVR:       host_rdata <= {14'b0, ovr};
            default:                host_rdata <= '0;     // unmapped
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/tx_dac_interleave.sv ====
// tx dac interleaver
// i on the high clock phase, q on the low phase, one 14-bit bus
// phase-selected registers stand in for a ddr output cell
`timescale 1ns/10ps
`default_nettype none

module tx_dac_interleave
  (
   input  logic                          clk_fpga,
   input  logic                          arst_n,
   input  u1e_pkg::tx_pair_t             tx_pair,
   output logic [u1e_pkg::DAC_W-1:0]     tx_dac,
   output logic                          tx_sync    // high marks the q phase
   );

   logic [u1e_pkg::DAC_W-1:0] i_rise;     // d0 side
   logic [u1e_pkg::DAC_W-1:0] q_delay;    // q lined up with its i
   logic [u1e_pkg::DAC_W-1:0] q_fall;     // d1 side

   ///////////////////////////////////////////////////////////////////////
   // rising edge capture
   always_ff @(posedge clk_fpga or negedge arst_n)
   begin
      if (!arst_n)
      begin
         i_rise  <= '0;
         q_delay <= '0;
      end
      else
      begin
         i_rise  <= tx_pair.i;
         q_delay <= tx_pair.q;
      end
   end

   // falling edge stage, q of the same pair half a cycle later
   always_ff @(negedge clk_fpga or negedge arst_n)
   begin
      if (!arst_n)
         q_fall <= '0;
      else
         q_fall <= q_delay;
   end

   // output cell, clock phase picks the driver
   assign tx_dac  = clk_fpga ? i_rise : q_fall;
   assign tx_sync = ~clk_fpga;            // 0 with i, 1 with q

endmodule

`default_nettype wire

// ==== verilog/rx_adc_capture.sv ====
// rx adc capture
// two register stages on DA/DB, sign extension to host width,
// sticky overrange flags per channel
`timescale 1ns/10ps
`default_nettype none

module rx_adc_capture
  (
   input  logic                          clk_fpga,
   input  logic                          arst_n,
   input  logic [u1e_pkg::ADC_W-1:0]     adc_a,
   input  logic [u1e_pkg::ADC_W-1:0]     adc_b,
   output u1e_pkg::rx_pair_t             rx_pair,
   output logic [1:0]                    ovr,       // bit 0 i, bit 1 q
   input  logic                          ovr_clear
   );

   localparam int EXT_W = u1e_pkg::REG_W - u1e_pkg::ADC_W;
   localparam logic [u1e_pkg::ADC_W-1:0] FS_POS = 12'h7ff;
   localparam logic [u1e_pkg::ADC_W-1:0] FS_NEG = 12'h800;

   logic [u1e_pkg::ADC_W-1:0] a_s1, b_s1;   // first stage, pad capture
   logic                      full_a, full_b;

   always_ff @(posedge clk_fpga)
   begin
      a_s1      <= adc_a;
      b_s1      <= adc_b;
      rx_pair.i <= {{EXT_W{a_s1[u1e_pkg::ADC_W-1]}}, a_s1};   // second stage, extended
      rx_pair.q <= {{EXT_W{b_s1[u1e_pkg::ADC_W-1]}}, b_s1};
   end

   ///////////////////////////////////////////////////////////////////////
   // overrange, full scale either way
   assign full_a = (a_s1 == FS_POS) || (a_s1 == FS_NEG);
   assign full_b = (b_s1 == FS_POS) || (b_s1 == FS_NEG);

   always_ff @(posedge clk_fpga or negedge arst_n)
   begin
      if (!arst_n)
         ovr <= 2'b00;
      else
         ovr <= {full_b, full_a} | (ovr & {2{~ovr_clear}});   // new hit beats clear
   end

endmodule

`default_nettype wire

// ==== verilog/u1e_radio_io.sv ====
// radio i/o top level
// host registers, peripheral spi master, tx dac interleave and rx adc capture
// clock-generator spi comes straight from the host aux pins
`timescale 1ns/10ps
`default_nettype none

module u1e_radio_io
  (
   input  logic                          clk_fpga,
   input  logic                          arst_n,
   // host word bus
   input  logic [u1e_pkg::ADDR_W-1:0]    host_addr,
   input  logic [u1e_pkg::REG_W-1:0]     host_wdata,
   input  logic                          host_we,
   output logic [u1e_pkg::REG_W-1:0]     host_rdata,
   // peripheral spi
   output logic                          db_sclk_rx,
   output logic                          db_sen_rx,
   output logic                          db_mosi_rx,
   input  logic                          db_miso_rx,
   output logic                          db_sclk_tx,
   output logic                          db_sen_tx,
   output logic                          db_mosi_tx,
   input  logic                          db_miso_tx,
   output logic                          sclk_codec,
   output logic                          sen_codec,
   output logic                          mosi_codec,
   input  logic                          miso_codec,
   // aux spi from host gpio, clock gen side
   input  logic                          aux_sclk,
   input  logic                          aux_sen_b,
   input  logic                          aux_mosi,
   output logic                          aux_miso,
   output logic                          cgen_sclk,
   output logic                          cgen_sen_b,
   output logic                          cgen_mosi,
   input  logic                          cgen_miso,
   input  logic                          cgen_st_status,
   input  logic                          cgen_st_ld,
   input  logic                          cgen_st_refmon,
   output logic                          cgen_sync_b,
   output logic                          cgen_ref_sel,
   // converters
   output logic [u1e_pkg::DAC_W-1:0]     tx_dac,
   output logic                          tx_sync,
   input  logic [u1e_pkg::ADC_W-1:0]     adc_a,
   input  logic [u1e_pkg::ADC_W-1:0]     adc_b
   );

   logic                                 spi_start;
   u1e_pkg::spi_cmd_t                    spi_cmd;
   logic                                 spi_busy;
   logic [u1e_pkg::SPI_MAX_BITS-1:0]     spi_rx_data;
   u1e_pkg::tx_pair_t                    tx_pair;
   u1e_pkg::rx_pair_t                    rx_pair;
   logic [1:0]                           ovr;
   logic                                 ovr_clear;

   ///////////////////////////////////////////////////////////////////////
   // clock gen spi bypasses the register bank
   assign cgen_sclk  = aux_sclk;
   assign cgen_sen_b = aux_sen_b;
   assign cgen_mosi  = aux_mosi;
   assign aux_miso   = cgen_miso;

   radio_regs radio_regs
     (.clk_fpga(clk_fpga), .arst_n(arst_n),
      .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we), .host_rdata(host_rdata),
      .spi_start(spi_start), .spi_cmd(spi_cmd), .spi_busy(spi_busy), .spi_rx_data(spi_rx_data),
      .tx_pair(tx_pair), .rx_pair(rx_pair), .ovr(ovr), .ovr_clear(ovr_clear),
      .cgen_sync_b(cgen_sync_b), .cgen_ref_sel(cgen_ref_sel),
      .cgen_status({cgen_st_status, cgen_st_ld, cgen_st_refmon}));

   // slave order 2 codec, 1 tx board, 0 rx board
   spi_master spi_master
     (.clk_fpga(clk_fpga), .arst_n(arst_n),
      .spi_start(spi_start), .spi_cmd(spi_cmd), .spi_busy(spi_busy), .spi_rx_data(spi_rx_data),
      .sclk({sclk_codec, db_sclk_tx, db_sclk_rx}),
      .mosi({mosi_codec, db_mosi_tx, db_mosi_rx}),
      .sen_n({sen_codec, db_sen_tx, db_sen_rx}),
      .miso({miso_codec, db_miso_tx, db_miso_rx}));

   tx_dac_interleave tx_dac_interleave
     (.clk_fpga(clk_fpga), .arst_n(arst_n),
      .tx_pair(tx_pair), .tx_dac(tx_dac), .tx_sync(tx_sync));

   rx_adc_capture rx_adc_capture
     (.clk_fpga(clk_fpga), .arst_n(arst_n),
      .adc_a(adc_a), .adc_b(adc_b),
      .rx_pair(rx_pair), .ovr(ovr), .ovr_clear(ovr_clear));

endmodule

`default_nettype wire

// ==== verification/u1e_radio_io_assert.sv ====
// bound checks for the radio i/o block
// slave enable rules on the spi master, sync phase on the dac interleaver
`timescale 1ns/10ps
`default_nettype none

module u1e_radio_io_assert
  #(parameter bit DAC_SIDE = 1'b0)       // 1 when bound to the dac cell
  (
   input logic                               clk_fpga,
   input logic                               arst_n,
   input logic [u1e_pkg::NUM_SLAVES-1:0]     sen_n,
   input logic [u1e_pkg::NUM_SLAVES-1:0]     sclk,
   input logic                               busy,
   input logic                               tx_sync
   );

   int unsigned fail_cnt = 0;            // failures so far

   generate
      if (DAC_SIDE)
      begin : g_dac
         logic mid_clk;                  // clk_fpga a quarter of the 10 ns period late
         assign #2.5 mid_clk = clk_fpga;

         // middle of the high phase, i on the bus
         a_sync_i: assert property (@(posedge mid_clk) disable iff (!arst_n) !tx_sync)
            else
            begin
               $error("tx_sync high in the i phase");
               fail_cnt++;
            end

         // middle of the low phase, q on the bus
         a_sync_q: assert property (@(negedge mid_clk) disable iff (!arst_n) tx_sync)
            else
            begin
               $error("tx_sync low in the q phase");
               fail_cnt++;
            end
      end
      else
      begin : g_spi
         a_one_sen: assert property (@(posedge clk_fpga) disable iff (!arst_n)
                                     $onehot0(~sen_n))
            else
            begin
               $error("more than one slave enable low");
               fail_cnt++;
            end

         // deselected slave never sees a clock
         a_sclk_gate: assert property (@(posedge clk_fpga) disable iff (!arst_n)
                                       (sclk & sen_n) == '0)
            else
            begin
               $error("spi clock on a deselected slave");
               fail_cnt++;
            end

         a_idle_sen: assert property (@(posedge clk_fpga) disable iff (!arst_n)
                                      !busy |-> (&sen_n))
            else
            begin
               $error("slave enable low while the master is idle");
               fail_cnt++;
            end
      end
   endgenerate

endmodule

////////////////////////////////////////////////////////////////////////
// spi rules on the master, sync phase on the dac cell
bind spi_master u1e_radio_io_assert #(.DAC_SIDE(1'b0)) spi_chk
  (.clk_fpga(clk_fpga), .arst_n(arst_n), .sen_n(sen_n), .sclk(sclk), .busy(spi_busy),
   .tx_sync(1'b0));

bind tx_dac_interleave u1e_radio_io_assert #(.DAC_SIDE(1'b1)) dac_chk
  (.clk_fpga(clk_fpga), .arst_n(arst_n), .sen_n('1), .sclk('0), .busy(1'b0),
   .tx_sync(tx_sync));

`default_nettype wire

// ==== verification/u1e_radio_io_tb.sv ====
// testbench for the radio i/o block
// host bus tasks, one spi slave model per peripheral, directed and random tests
`timescale 1ns/10ps
`default_nettype none

module u1e_radio_io_tb;

   localparam int XFER_CYC = 2 * u1e_pkg::SCLK_DIV * u1e_pkg::SPI_MAX_BITS;   // 192
   localparam int MAX_CYC  = 20000;      // six full transfers plus host traffic and margin
   localparam logic [23:0] SLAVE_RESP [3] = '{24'hA5C396, 24'h3C5AF0, 24'hD2B4E1};

   logic                          clk_fpga;
   logic                          arst_n;
   logic [u1e_pkg::ADDR_W-1:0]    host_addr;
   logic [u1e_pkg::REG_W-1:0]     host_wdata;
   logic                          host_we;
   wire  [u1e_pkg::REG_W-1:0]     host_rdata;
   wire  [2:0]                    sclk_v, sen_v, mosi_v;     // 0 rx board, 1 tx board, 2 codec
   logic [2:0]                    miso_v = '0;
   logic                          aux_sclk, aux_sen_b, aux_mosi, cgen_miso;
   wire                           aux_miso, cgen_sclk, cgen_sen_b, cgen_mosi;
   wire                           cgen_sync_b, cgen_ref_sel;
   logic [2:0]                    cgen_st;                   // status, lock, refmon
   wire  [u1e_pkg::DAC_W-1:0]     tx_dac;
   wire                           tx_sync;
   logic [u1e_pkg::ADC_W-1:0]     adc_a, adc_b;
   wire  [31:0]                   clk_cnt_v [0:2];           // per model
   wire  [23:0]                   rx_bits_v [0:2];
   wire  [4:0]                    frame_len_v [0:2];
   wire  [2:0]                    out_bit_v;
   int                            seed = 18121;
   int                            errors, test_err, tests_run, cyc;

   u1e_radio_io UUT
     (.clk_fpga(clk_fpga), .arst_n(arst_n),
      .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we), .host_rdata(host_rdata),
      .db_sclk_rx(sclk_v[0]), .db_sen_rx(sen_v[0]), .db_mosi_rx(mosi_v[0]), .db_miso_rx(miso_v[0]),
      .db_sclk_tx(sclk_v[1]), .db_sen_tx(sen_v[1]), .db_mosi_tx(mosi_v[1]), .db_miso_tx(miso_v[1]),
      .sclk_codec(sclk_v[2]), .sen_codec(sen_v[2]), .mosi_codec(mosi_v[2]), .miso_codec(miso_v[2]),
      .aux_sclk(aux_sclk), .aux_sen_b(aux_sen_b), .aux_mosi(aux_mosi), .aux_miso(aux_miso),
      .cgen_sclk(cgen_sclk), .cgen_sen_b(cgen_sen_b), .cgen_mosi(cgen_mosi), .cgen_miso(cgen_miso),
      .cgen_st_status(cgen_st[2]), .cgen_st_ld(cgen_st[1]), .cgen_st_refmon(cgen_st[0]),
      .cgen_sync_b(cgen_sync_b), .cgen_ref_sel(cgen_ref_sel),
      .tx_dac(tx_dac), .tx_sync(tx_sync), .adc_a(adc_a), .adc_b(adc_b));

   initial
   begin
      clk_fpga = 1'b0;
      forever #5 clk_fpga = ~clk_fpga;
   end

   ////////////////////////////////////////////////////////////////////////
   // slave models, mode 0, response sent msb first
   genvar g;
   generate
      for (g = 0; g < 3; g++)
      begin : slave_model
         int unsigned clk_cnt   = 0;     // every rising clock since start
         logic [23:0] rx_sr     = '0;    // current frame, right aligned
         logic [4:0]  frame_len = '0;

         always @(negedge sen_v[g] or posedge sclk_v[g])
         begin
            if (sclk_v[g])
            begin
               clk_cnt   <= clk_cnt + 1;
               rx_sr     <= {rx_sr[22:0], mosi_v[g]};
               frame_len <= frame_len + 1'b1;
            end
            else
            begin                        // new frame
               rx_sr     <= '0;
               frame_len <= '0;
            end
         end

         assign out_bit_v[g]   = (frame_len < 5'd24) ? SLAVE_RESP[g][5'd23 - frame_len] : 1'b0;
         assign clk_cnt_v[g]   = clk_cnt;
         assign rx_bits_v[g]   = rx_sr;
         assign frame_len_v[g] = frame_len;
      end
   endgenerate

   always @(negedge clk_fpga)
      miso_v <= ~sen_v & out_bit_v;      // only an enabled slave drives

   ////////////////////////////////////////////////////////////////////////
   // host bus and reporting
   task automatic host_write(input logic [3:0] addr, input logic [15:0] data);
      @(negedge clk_fpga);
      host_addr  = addr;
      host_wdata = data;
      host_we    = 1'b1;
      @(negedge clk_fpga);
      host_we    = 1'b0;
   endtask

   task automatic host_read(input logic [3:0] addr, output logic [15:0] data);
      @(negedge clk_fpga);
      host_addr = addr;
      @(negedge clk_fpga);               // registered one cycle later
      data = host_rdata;
   endtask

   task automatic check(input logic ok, input string msg);
      assert (ok)
      else
      begin
         $display("FAIL %0t: %s", $time, msg);
         test_err++;
      end
   endtask

   task automatic report_test(input string name);
      if (test_err == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, test_err);
      errors += test_err;
      tests_run++;
      test_err = 0;
   endtask

   task automatic spi_send(input int slave, input int nbits, input logic [23:0] data);
      host_write(u1e_pkg::REG_SPI_LO, data[15:0]);
      host_write(u1e_pkg::REG_SPI_HI, {8'h00, data[23:16]});
      host_write(u1e_pkg::REG_SPI_CTRL, 16'((nbits << 4) | slave));
   endtask

   task automatic wait_spi_idle();
      logic [15:0] r;
      int          polls;
      polls = 0;
      do
      begin
         host_read(u1e_pkg::REG_SPI_CTRL, r);
         polls++;
      end
      while (r[0] && polls < XFER_CYC);
      check(!r[0], "spi busy never dropped");
   endtask

   initial
   begin
      cyc = 0;
      forever
      begin
         @(posedge clk_fpga);
         cyc++;
         if (cyc >= MAX_CYC)
         begin
            $display("timeout, run went past %0d clock cycles", MAX_CYC);
            $display("SIMULATION FAILED");
            $finish;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // tests
   initial
   begin
      logic [15:0]        r;
      logic [23:0]        d, got;
      logic [13:0]        ti, tq;
      logic [11:0]        a, b;
      logic signed [15:0] ext;
      logic [4:0]         len_codec;
      logic [2:0]         st;
      int                 n, bound_fails;
      int unsigned        cnt0 [3];
      errors     = 0;
      test_err   = 0;
      tests_run  = 0;
      arst_n     = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      host_we    = 1'b0;
      {aux_sclk, aux_sen_b, aux_mosi, cgen_miso} = 4'h0;
      cgen_st    = 3'b000;
      adc_a      = '0;
      adc_b      = '0;
      repeat (10) @(posedge clk_fpga);
      @(negedge clk_fpga);
      arst_n = 1'b1;

      // tx interleave, i while clk high, q while clk low
      repeat (4)
      begin
         ti = $random(seed);
         tq = $random(seed);
         host_write(u1e_pkg::REG_TX_I, {2'b00, ti});
         host_write(u1e_pkg::REG_TX_Q, {2'b00, tq});
         @(posedge clk_fpga);
         #2.5;
         check(tx_dac == ti && !tx_sync,
               $sformatf("i phase dac %h sync %b, expected %h sync 0", tx_dac, tx_sync, ti));
         @(negedge clk_fpga);
         #2.5;
         check(tx_dac == tq && tx_sync,
               $sformatf("q phase dac %h sync %b, expected %h sync 1", tx_dac, tx_sync, tq));
      end
      report_test("tx interleave");

      // one random transfer per slave
      for (int s = 0; s < 3; s++)
      begin
         n = 1 + ($unsigned($random(seed)) % 24);
         d = 24'($random(seed)) & ((24'h1 << n) - 24'h1);
         for (int k = 0; k < 3; k++)
            cnt0[k] = clk_cnt_v[k];
         spi_send(s, n, d);
         wait_spi_idle();
         check(frame_len_v[s] == n && rx_bits_v[s] == d,
               $sformatf("slave %0d got %0d bits %h, expected %0d bits %h",
                         s, frame_len_v[s], rx_bits_v[s], n, d));
         for (int k = 0; k < 3; k++)
            if (k != s)
               check(clk_cnt_v[k] == cnt0[k], $sformatf("slave %0d clocked out of turn", k));
         host_read(u1e_pkg::REG_SPI_RX_LO, r);
         got[15:0] = r;
         host_read(u1e_pkg::REG_SPI_RX_HI, r);
         got[23:16] = r[7:0];
         check(got == (SLAVE_RESP[s] >> (24 - n)),
               $sformatf("slave %0d read back %h, expected %h", s, got, SLAVE_RESP[s] >> (24 - n)));
      end
      report_test("spi per slave");

      // rejected control writes, busy, bad index, bad length
      for (int k = 0; k < 3; k++)
         cnt0[k] = clk_cnt_v[k];
      len_codec = frame_len_v[2];                    // last codec frame, at least one bit
      spi_send(0, 24, 24'h5A5A5A);
      host_write(u1e_pkg::REG_SPI_CTRL, 16'h0181);   // slave 1 while busy
      host_write(u1e_pkg::REG_SPI_CTRL, 16'h0183);   // slave 3 while busy
      wait_spi_idle();
      host_write(u1e_pkg::REG_SPI_CTRL, 16'h0183);   // slave 3 while idle
      host_write(u1e_pkg::REG_SPI_CTRL, 16'h0002);   // zero length
      host_write(u1e_pkg::REG_SPI_CTRL, 16'h0192);   // 25 bits
      host_read(u1e_pkg::REG_SPI_CTRL, r);
      check(!r[0], "a rejected command started the spi engine");
      check(clk_cnt_v[0] == cnt0[0] + 24 && clk_cnt_v[1] == cnt0[1] && clk_cnt_v[2] == cnt0[2],
            $sformatf("clock counts %0d %0d %0d, expected %0d %0d %0d", clk_cnt_v[0],
                      clk_cnt_v[1], clk_cnt_v[2], cnt0[0] + 24, cnt0[1], cnt0[2]));
      // a codec enable pulse would restart its frame
      check(frame_len_v[2] == len_codec,
            $sformatf("codec frame length %0d, expected %0d", frame_len_v[2], len_codec));
      report_test("spi busy rule");

      // rx capture and sign extension
      repeat (4)
      begin
         @(negedge clk_fpga);
         a = $random(seed);
         b = $random(seed);
         adc_a = a;
         adc_b = b;
         repeat (4) @(negedge clk_fpga);
         host_read(u1e_pkg::REG_RX_I, r);
         ext = $signed(a);
         check(r == ext, $sformatf("rx_i %h for adc_a %h", r, a));
         host_read(u1e_pkg::REG_RX_Q, r);
         ext = $signed(b);
         check(r == ext, $sformatf("rx_q %h for adc_b %h", r, b));
      end
      report_test("rx capture");

      // sticky overrange on channel a only
      @(negedge clk_fpga);
      adc_a = 12'h123;
      adc_b = 12'h456;
      repeat (4) @(negedge clk_fpga);
      host_write(u1e_pkg::REG_OVR, 16'h0000);
      host_read(u1e_pkg::REG_OVR, r);
      check(r == 16'h0000, $sformatf("overrange %h after clear, expected 0000", r));
      adc_a = 12'h7FF;
      repeat (2) @(negedge clk_fpga);
      adc_a = 12'h123;
      repeat (4) @(negedge clk_fpga);
      host_read(u1e_pkg::REG_OVR, r);
      check(r == 16'h0001, $sformatf("overrange %h after full scale a, expected 0001", r));
      host_read(u1e_pkg::REG_OVR, r);
      check(r == 16'h0001, $sformatf("overrange %h not sticky, expected 0001", r));
      host_write(u1e_pkg::REG_OVR, 16'h0001);
      host_read(u1e_pkg::REG_OVR, r);
      check(r == 16'h0000, $sformatf("overrange %h after second clear, expected 0000", r));
      report_test("overrange");

      // clock generator controls, status and aux pass-through
      check(cgen_sync_b && !cgen_ref_sel, "clock gen pins not at reset values");
      for (int k = 0; k < 4; k++)
      begin
         st = $random(seed);
         host_write(u1e_pkg::REG_CGEN, 16'(k));
         check(cgen_sync_b == k[0] && cgen_ref_sel == k[1],
               $sformatf("sync_b %b ref_sel %b after writing %0d", cgen_sync_b, cgen_ref_sel, k));
         cgen_st = st;
         host_read(u1e_pkg::REG_CGEN, r);
         check(r == {11'b0, st, k[1], k[0]}, $sformatf("cgen read %h with status %b", r, st));
      end
      for (int k = 0; k < 16; k++)
      begin
         @(negedge clk_fpga);
         {aux_sclk, aux_sen_b, aux_mosi, cgen_miso} = 4'(k);
         #1;
         check({cgen_sclk, cgen_sen_b, cgen_mosi, aux_miso} == 4'(k),
               $sformatf("aux pass-through wrong for pattern %h", k));
      end
      report_test("clock generator");

      bound_fails = UUT.spi_master.spi_chk.fail_cnt + UUT.tx_dac_interleave.dac_chk.fail_cnt;
      $display("summary: %0d tests, %0d check errors, %0d bound assertion failures",
               tests_run, errors, bound_fails);
      if (errors == 0 && bound_fails == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/u1e_pkg.sv
verilog/spi_master.sv
verilog/radio_regs.sv
verilog/tx_dac_interleave.sv
verilog/rx_adc_capture.sv
verilog/u1e_radio_io.sv
verification/u1e_radio_io_assert.sv
verification/u1e_radio_io_tb.sv
